/* common/sys_pkg.sv */
// --------------------------------------------------------------------------
// system types and constants shared by the processor system
// bus widths, boot image size, watch address and sequencer states
// --------------------------------------------------------------------------

package sys_pkg;

	// --------------------------------------------------------------------------
	// widths
	// --------------------------------------------------------------------------
	localparam int ADDR_BITS     = 8;
	localparam int DATA_BITS     = 8;
	localparam int BOOT_IDX_BITS = 4;

	// full address space of the ram
	localparam int RAM_WORDS = 2 ** ADDR_BITS;

	typedef logic [ADDR_BITS - 1 : 0]     addr_t;
	typedef logic [DATA_BITS - 1 : 0]     data_t;
	typedef logic [BOOT_IDX_BITS - 1 : 0] boot_idx_t;

	// --------------------------------------------------------------------------
	// system defaults
	// --------------------------------------------------------------------------
	// image length, top level may override
	localparam int BOOT_WORDS = 16;

	// writes here show up on the watch output
	localparam addr_t WATCH_ADDR_DEFAULT = 8'hff;

	// bring-up sequence
	typedef enum logic [1 : 0] {
		SYS_RESET,
		SYS_BOOT,
		SYS_RUN
	} sys_state_t;

endpackage

/* common/cpu_isa_pkg.sv */
// --------------------------------------------------------------------------
// instruction set of the 8-bit accumulator cpu
// --------------------------------------------------------------------------

package cpu_isa_pkg;

	// instruction format: opcode byte then operand byte
	localparam int OPCODE_BITS    = 8;
	localparam int INSTR_BYTES    = 2;
	localparam int OPERAND_OFFSET = 1;

	// program counter after reset
	localparam int RESET_PC = 0;

	// unlisted codes behave like hlt
	typedef enum logic [OPCODE_BITS - 1 : 0] {
		OP_HLT = 8'd0,
		OP_LDI = 8'd1,
		OP_LD  = 8'd2,
		OP_ST  = 8'd3,
		OP_ADD = 8'd4,
		OP_SUB = 8'd5,
		OP_JMP = 8'd6,
		OP_JNZ = 8'd7
	} opcode_t;

endpackage

/* common/wb_if.sv */
// --------------------------------------------------------------------------
// wishbone classic bus, 8-bit address and data
// --------------------------------------------------------------------------

interface wb_if;
	import sys_pkg::*;

	// cycle and strobe, raised together by the master
	logic cyc;
	logic stb;
	logic we;
	addr_t adr;
	data_t dat_w;

	// slave response, ack lasts one cycle
	data_t dat_r;
	logic ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

/* hdl/wb_arbiter.sv */
// --------------------------------------------------------------------------
// two-master wishbone arbiter, m0 has priority
// grant stays with its owner for as long as the owner holds cyc
// --------------------------------------------------------------------------

module wb_arbiter (
	input logic clock,
	input logic reset,
	wb_if.slave m0,
	wb_if.slave m1,
	wb_if.master s
);

	// grant: 0 selects m0, 1 selects m1
	logic grant;
	logic owner_q;
	logic locked_q;
	logic owner_cyc;

	// --------------------------------------------------------------------------
	// grant selection
	// --------------------------------------------------------------------------
	assign owner_cyc = owner_q ? m1.cyc : m0.cyc;

	always_comb begin
		if (locked_q && owner_cyc) begin
			// owner still inside its cycle
			grant = owner_q;
		end else if (m0.cyc) begin
			grant = 1'b0;
		end else begin
			// default to m1, harmless when idle
			grant = 1'b1;
		end
	end

	// remember who holds the bus
	always_ff @(posedge clock) begin
		if (reset) begin
			owner_q  <= 1'b0;
			locked_q <= 1'b0;
		end else begin
			owner_q  <= grant;
			locked_q <= s.cyc;
		end
	end

	// --------------------------------------------------------------------------
	// request and response routing
	// --------------------------------------------------------------------------
	assign s.cyc   = grant ? m1.cyc   : m0.cyc;
	assign s.stb   = grant ? m1.stb   : m0.stb;
	assign s.we    = grant ? m1.we    : m0.we;
	assign s.adr   = grant ? m1.adr   : m0.adr;
	assign s.dat_w = grant ? m1.dat_w : m0.dat_w;

	// loser sees no ack and no data
	assign m0.ack   = s.ack & ~grant;
	assign m1.ack   = s.ack & grant;
	assign m0.dat_r = grant ? '0 : s.dat_r;
	assign m1.dat_r = grant ? s.dat_r : '0;

	// ownership moves only between cycles or on the closing ack
	grant_stable: assert property (
		@(posedge clock) disable iff (reset)
		(grant != $past(grant)) |-> $past(!s.cyc || s.ack)
	);

endmodule

/* hdl/wb_ram_watch.sv */
// --------------------------------------------------------------------------
// 256-byte wishbone ram with one wait cycle
// writes to the watch address are also copied to the watch register
// --------------------------------------------------------------------------

module wb_ram_watch #(
	parameter sys_pkg::addr_t watch_addr = sys_pkg::WATCH_ADDR_DEFAULT
) (
	input logic clock,
	input logic reset,
	wb_if.slave bus,
	output sys_pkg::data_t watch
);
	import sys_pkg::*;

	data_t mem [RAM_WORDS];
	data_t rd_q;
	data_t watch_q;
	logic ack_q;
	logic req;

	// new request, not the one being acked
	assign req = bus.cyc && bus.stb && !ack_q;

	// storage and read data
	always_ff @(posedge clock) begin
		if (req) begin
			if (bus.we) begin
				mem[bus.adr] <= bus.dat_w;
			end
			rd_q <= mem[bus.adr];
		end
	end

	// ack one cycle late, watch register
	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q   <= 1'b0;
			watch_q <= '0;
		end else begin
			ack_q <= req;
			if (req && bus.we && bus.adr == watch_addr) begin
				watch_q <= bus.dat_w;
			end
		end
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = rd_q;
	assign watch     = watch_q;

	// the granted master must still be strobing when ack arrives
	ack_with_stb: assert property (
		@(posedge clock) disable iff (reset)
		bus.ack |-> bus.stb
	);

endmodule

/* boot/boot_copier.sv */
// --------------------------------------------------------------------------
// boot copier, writes the external boot image into ram word by word
// --------------------------------------------------------------------------

module boot_copier #(
	parameter int boot_words = sys_pkg::BOOT_WORDS
) (
	input logic clock,
	input logic reset,
	output sys_pkg::boot_idx_t boot_addr,
	input sys_pkg::data_t boot_data,
	wb_if.master bus,
	output logic done
);
	import sys_pkg::*;

	boot_idx_t idx;
	logic busy_q;
	logic done_q;
	logic last;

	// final word of the image
	assign last = (idx == boot_idx_t'(boot_words - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			idx    <= '0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else if (!busy_q && !done_q) begin
			// start right after reset is released
			busy_q <= 1'b1;
		end else if (busy_q && bus.ack) begin
			if (last) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// boot index stays put until the word is acked
	assign boot_addr = idx;

	// image lands at the same ram address
	assign bus.cyc   = busy_q;
	assign bus.stb   = busy_q;
	assign bus.we    = 1'b1;
	assign bus.adr   = addr_t'(idx);
	assign bus.dat_w = boot_data;

	// done already in the cycle of the last ack
	assign done = done_q | (busy_q & bus.ack & last);

endmodule

/* cpu/cpu8.sv */
// --------------------------------------------------------------------------
// multi-cycle 8-bit accumulator cpu
// fetches two-byte instructions and reaches memory over wishbone
// --------------------------------------------------------------------------

module cpu8 (
	input logic clock,
	input logic reset,
	wb_if.master bus,
	output logic halted
);
	import sys_pkg::*;
	import cpu_isa_pkg::*;

	typedef enum logic [1 : 0] {
		CPU_FETCH_OP,
		CPU_FETCH_ARG,
		CPU_MEM,
		CPU_HALT
	} cpu_state_t;

	cpu_state_t state;
	addr_t pc;
	data_t acc;
	opcode_t ir;
	data_t opr;

	addr_t pc_next;
	logic active;

	// sequential instruction address
	assign pc_next = pc + addr_t'(INSTR_BYTES);

	// --------------------------------------------------------------------------
	// bus request, one access per state
	// --------------------------------------------------------------------------
	// no request while held in reset or once stopped
	assign active = !reset && (state != CPU_HALT);

	assign bus.cyc   = active;
	assign bus.stb   = active;
	assign bus.we    = (state == CPU_MEM) && (ir == OP_ST);
	assign bus.dat_w = acc;

	always_comb begin
		case (state)
			CPU_FETCH_ARG: bus.adr = pc + addr_t'(OPERAND_OFFSET);
			CPU_MEM:       bus.adr = opr;
			default:       bus.adr = pc;
		endcase
	end

	// --------------------------------------------------------------------------
	// control
	// --------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CPU_FETCH_OP;
			pc    <= addr_t'(RESET_PC);
			acc   <= '0;
		end else if (bus.ack) begin
			case (state)
				CPU_FETCH_OP: begin
					state <= CPU_FETCH_ARG;
				end

				CPU_FETCH_ARG: begin
					// operand byte decides the rest
					case (ir)
						OP_LDI: begin
							acc   <= bus.dat_r;
							pc    <= pc_next;
							state <= CPU_FETCH_OP;
						end
						OP_LD, OP_ST, OP_ADD, OP_SUB: begin
							state <= CPU_MEM;
						end
						OP_JMP: begin
							pc    <= bus.dat_r;
							state <= CPU_FETCH_OP;
						end
						OP_JNZ: begin
							pc    <= (acc != '0) ? bus.dat_r : pc_next;
							state <= CPU_FETCH_OP;
						end
						default: begin
							// hlt and unknown codes
							state <= CPU_HALT;
						end
					endcase
				end

				CPU_MEM: begin
					case (ir)
						OP_LD:   acc <= bus.dat_r;
						OP_ADD:  acc <= acc + bus.dat_r;
						OP_SUB:  acc <= acc - bus.dat_r;
						default: acc <= acc;
					endcase
					pc    <= pc_next;
					state <= CPU_FETCH_OP;
				end

				default: begin
					state <= CPU_HALT;
				end
			endcase
		end
	end

	// instruction and operand registers
	always_ff @(posedge clock) begin
		if (bus.ack && state == CPU_FETCH_OP) begin
			ir <= opcode_t'(bus.dat_r);
		end
		if (bus.ack && state == CPU_FETCH_ARG) begin
			opr <= bus.dat_r;
		end
	end

	assign halted = (state == CPU_HALT);

	// an ack reaches the cpu only for a request it holds open
	ack_in_cycle: assert property (
		@(posedge clock) disable iff (reset)
		bus.ack |-> (bus.cyc && bus.stb)
	);

endmodule

/* hdl/cpu_system.sv */
// --------------------------------------------------------------------------
// processor system top, boots ram from the boot port then runs the cpu
// --------------------------------------------------------------------------

module cpu_system #(
	parameter int boot_words = sys_pkg::BOOT_WORDS,
	parameter sys_pkg::addr_t watch_addr = sys_pkg::WATCH_ADDR_DEFAULT
) (
	input logic clock,
	input logic reset,
	input sys_pkg::data_t boot_data,
	output sys_pkg::boot_idx_t boot_addr,
	output logic booting,
	output logic running,
	output logic halted,
	output logic write_active,
	output sys_pkg::data_t watch
);
	import sys_pkg::*;

	sys_state_t state;
	logic copy_done;
	logic copier_reset;
	logic cpu_reset;

	// --------------------------------------------------------------------------
	// boot and run sequencer
	// --------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SYS_RESET;
		end else begin
			case (state)
				SYS_RESET: state <= SYS_BOOT;
				SYS_BOOT:  state <= copy_done ? SYS_RUN : SYS_BOOT;
				default:   state <= SYS_RUN;
			endcase
		end
	end

	// copier free from boot on, cpu only in run
	assign copier_reset = reset || (state == SYS_RESET);
	assign cpu_reset    = reset || (state != SYS_RUN);

	assign booting = (state == SYS_BOOT);
	assign running = (state == SYS_RUN);

	// --------------------------------------------------------------------------
	// bus masters, arbiter and ram
	// --------------------------------------------------------------------------
	wb_if boot_bus ();
	wb_if cpu_bus ();
	wb_if ram_bus ();

	boot_copier #(.boot_words(boot_words)) copier (
		.clock(clock),
		.reset(copier_reset),
		.boot_addr(boot_addr),
		.boot_data(boot_data),
		.bus(boot_bus),
		.done(copy_done)
	);

	cpu8 cpu (
		.clock(clock),
		.reset(cpu_reset),
		.bus(cpu_bus),
		.halted(halted)
	);

	// boot port first
	wb_arbiter arbiter (
		.clock(clock),
		.reset(reset),
		.m0(boot_bus),
		.m1(cpu_bus),
		.s(ram_bus)
	);

	wb_ram_watch #(.watch_addr(watch_addr)) ram (
		.clock(clock),
		.reset(reset),
		.bus(ram_bus),
		.watch(watch)
	);

	// write in progress on the ram
	assign write_active = ram_bus.cyc & ram_bus.we;

endmodule

/* tb/tb_cpu_system.sv */
// --------------------------------------------------------------------------
// testbench for the processor system, serves the boot port from a file
// and checks boot order, sequencing and the watch sequence over two runs
// --------------------------------------------------------------------------

module tb_cpu_system;
	import sys_pkg::*;

	logic clock;
	logic reset;
	data_t boot_data;
	boot_idx_t boot_addr;
	logic booting;
	logic running;
	logic halted;
	logic write_active;
	data_t watch;

	// image and expectations from the data file
	data_t image [16];
	data_t exp_watch[$];
	int n_boot;
	int cycle_limit;

	// run state shared with the monitor
	boot_idx_t boot_seq[$];
	int watch_idx;
	int cycles;
	logic checking;
	data_t prev_watch;
	logic prev_write;
	logic prev_running;

	cpu_system dut (
		.clock(clock),
		.reset(reset),
		.boot_data(boot_data),
		.boot_addr(boot_addr),
		.booting(booting),
		.running(running),
		.halted(halted),
		.write_active(write_active),
		.watch(watch)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------
	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s, got %0d, expected %0d",
				$time, msg, actual, expected);
			$display("Test FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// one clock, bounded by the run limit
	task automatic step_cycle(input string what);
		@(negedge clock);
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles while waiting for %s", cycles, what);
			$display("Test FAILED");
			$fatal(1, "run did not finish in time");
		end
	endtask

	task automatic load_program_file();
		int fd;
		int code;
		int done_reading;
		logic [7 : 0] tag;
		logic [31 : 0] addr_v;
		logic [31 : 0] data_v;
		logic [8 * 128 - 1 : 0] line;
		fd = $fopen("tb/prog_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the boot image file tb/prog_input.txt");
			$display("Test FAILED");
			$fatal(1, "missing input file");
		end
		done_reading = 0;
		while (!done_reading) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				done_reading = 1;
			end else begin
				case (tag)
					"P": begin
						code = $fscanf(fd, "%h %h", addr_v, data_v);
						check(addr_v < 16, 1, "image address inside the boot port");
						image[addr_v[3 : 0]] = data_t'(data_v);
					end
					"W": begin
						code = $fscanf(fd, "%h", data_v);
						exp_watch.push_back(data_t'(data_v));
					end
					"N": begin
						code = $fscanf(fd, "%d", data_v);
						n_boot = data_v;
					end
					// comment up to end of line
					default: code = $fgets(line, fd);
				endcase
			end
		end
		$fclose(fd);
	endtask

	// three cycles of reset, outputs must all be low at the end
	task automatic apply_reset();
		@(posedge clock);
		checking = 1'b0;
		@(negedge clock);
		reset = 1'b1;
		watch_idx = 0;
		boot_seq.delete();
		repeat (2) @(negedge clock);
		check({booting, running, halted, write_active}, 0, "status low in reset");
		check(watch, 0, "watch cleared by reset");
		@(negedge clock);
		reset = 1'b0;
		cycles = 0;
		@(posedge clock);
		checking = 1'b1;
	endtask

	task automatic boot_and_run(input int run_no);
		apply_reset();
		while (!booting) step_cycle("booting to rise");
		check(running, 0, "running low at boot start");
		check(halted, 0, "halted low at boot start");
		while (booting) step_cycle("booting to fall");
		// boot port visited in order, once each
		check(boot_seq.size(), n_boot, "number of boot addresses");
		foreach (boot_seq[i]) begin
			check(boot_seq[i], i, "boot address order");
		end
		check(running, 1, "running after boot");
		while (!halted) step_cycle("halted to rise");
		check(watch_idx, exp_watch.size(), "watch changes seen before halt");
		check(watch, exp_watch[exp_watch.size() - 1], "final watch value");
		$display("run %0d halted after %0d cycles", run_no, cycles);
	endtask

	// --------------------------------------------------------------------------
	// boot port, answers the address of the current word
	// --------------------------------------------------------------------------
	always @(negedge clock) begin
		boot_data = image[boot_addr];
	end

	// --------------------------------------------------------------------------
	// monitor, sampled mid-cycle
	// --------------------------------------------------------------------------
	always @(negedge clock) begin
		if (checking) begin
			check(booting & running, 0, "booting and running high together");
			if (booting) begin
				if (boot_seq.size() == 0 || boot_seq[$] != boot_addr) begin
					boot_seq.push_back(boot_addr);
				end
			end
			// run may only start once the copy is complete
			if (running && !prev_running) begin
				check(boot_seq.size(), n_boot, "boot words copied when running rose");
			end
			if (watch != prev_watch) begin
				check(write_active | prev_write, 1, "watch changed without a ram write");
				if (watch_idx >= exp_watch.size()) begin
					// list used up, any further change is wrong
					check(watch, prev_watch, "watch change beyond the expected list");
				end else begin
					check(watch, exp_watch[watch_idx], "watch value");
					watch_idx++;
				end
			end
		end
		prev_watch = watch;
		prev_write = write_active;
		prev_running = running;
	end

	// --------------------------------------------------------------------------
	// main sequence
	// --------------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		boot_data = '0;
		checking = 1'b0;
		n_boot = 0;
		cycles = 0;
		watch_idx = 0;
		cycle_limit = 1000;
		foreach (image[i]) begin
			image[i] = '0;
		end
		load_program_file();
		check(n_boot > 0, 1, "boot length given in the input file");
		check(exp_watch.size() > 0, 1, "watch values given in the input file");
		// copy, then a generous bound per expected store
		cycle_limit = 2 * n_boot + 20 * exp_watch.size() + 60;
		boot_and_run(1);
		// second boot must give the same result
		boot_and_run(2);
		$display("Test OK");
		$finish;
	end

endmodule

/* tb/prog_input.txt */
# P <addr hex> <byte hex> boot image word, W <value hex> next watch value
# N <count decimal> expected number of boot words
P 00 01 # ldi 5
P 01 05
P 02 03 # st ff
P 03 ff
P 04 05 # sub mem[0e]
P 05 0e
P 06 07 # jnz 02
P 07 02
P 08 03 # st ff, stores the final 0
P 09 ff
P 0a 00 # hlt
P 0b 00
P 0c 00
P 0d 00
P 0e 01 # constant 1
P 0f 00
W 05
W 04
W 03
W 02
W 01
W 00
N 16

/* src.f */
common/sys_pkg.sv
common/cpu_isa_pkg.sv
common/wb_if.sv
hdl/wb_arbiter.sv
hdl/wb_ram_watch.sv
boot/boot_copier.sv
cpu/cpu8.sv
hdl/cpu_system.sv
tb/tb_cpu_system.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  # packages and interface first
  - common/sys_pkg.sv
  - common/cpu_isa_pkg.sv
  - common/wb_if.sv
  # design
  - hdl/wb_arbiter.sv
  - hdl/wb_ram_watch.sv
  - boot/boot_copier.sv
  - cpu/cpu8.sv
  - hdl/cpu_system.sv
  # testbench
  - target: simulation
    files:
      - tb/tb_cpu_system.sv
